/* flit_pkg.sv */
package flit_pkg;

  // Flit layout, MSB first:
  //   63      virtual channel, carried through
  //   62      north-south direction, carried through
  //   61      east-west direction
  //   60:56   reserved
  //   55:52   y hop count, carried through
  //   51:48   x hop count
  //   47:32   source coordinates
  //   31:0    payload
  localparam int FLIT_WIDTH    = 64;
  localparam int EAST_WEST_BIT = 61;
  localparam int X_HOP_MSB     = 51;
  localparam int X_HOP_LSB     = 48;

  // Value of the east-west bit for traffic heading east
  localparam logic WEST_TO_EAST = 1'b1;

  // One whole flit as it moves through the router
  typedef logic [FLIT_WIDTH-1:0] flit_t;

  // Remaining hops along the ring
  typedef logic [X_HOP_MSB-X_HOP_LSB:0] hop_t;

  // Data word in the low half of the flit
  typedef logic [31:0] payload_t;

endpackage

/* router_cfg_pkg.sv */
package router_cfg_pkg;

  // One input and one output per port
  localparam int NUM_PORTS = 3;

  // FIFO slots per input port, and so the credits each output starts with
  localparam int BUFFER_DEPTH = 4;

  // The encoding doubles as the bit position in every per-port vector
  typedef enum logic [1:0] {
    PORT_CW  = 2'd0,
    PORT_CCW = 2'd1,
    PORT_PE  = 2'd2
  } port_e;

  // Must hold every value from 0 up to BUFFER_DEPTH
  typedef logic [2:0] credit_t;

  // One bit per port, used for routes, requests and grants
  typedef logic [NUM_PORTS-1:0] port_mask_t;

endpackage

/* input_port.sv */
module input_port
  import flit_pkg::*;
  import router_cfg_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       in_valid,
  input  flit_t      in_flit,
  input  logic       is_pe_port,
  input  port_e      own_port,
  input  logic       pop,
  output logic       credit_out,
  output logic       head_valid,
  output flit_t      head_flit,
  output port_mask_t route
);

  flit_t                             mem [BUFFER_DEPTH];
  logic [$clog2(BUFFER_DEPTH)-1:0]   wr_ptr;
  logic [$clog2(BUFFER_DEPTH)-1:0]   rd_ptr;
  credit_t                           count;
  hop_t                              head_hops;

  // Flit storage, written whenever upstream sends
  always_ff @(posedge clk) begin
    if (in_valid) begin
      mem[wr_ptr] <= in_flit;
    end
  end

  // Pointers wrap naturally since the depth is a power of two
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      credit_out <= 1'b0;
    end else begin
      if (in_valid) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count      <= count + credit_t'(in_valid) - credit_t'(pop);
      // Every freed slot goes back upstream as one credit
      credit_out <= pop;
    end
  end

  assign head_valid = (count != '0);
  assign head_flit  = mem[rd_ptr];
  assign head_hops  = head_flit[X_HOP_MSB:X_HOP_LSB];

  // Route of the head flit, one bit set
  always_comb begin
    route = '0;
    if (head_hops != '0) begin
      if (is_pe_port) begin
        // Injected traffic picks its ring from the east-west bit
        if (head_flit[EAST_WEST_BIT] == WEST_TO_EAST) begin
          route[PORT_CW] = 1'b1;
        end else begin
          route[PORT_CCW] = 1'b1;
        end
      end else begin
        route[own_port] = 1'b1;
      end
    end else begin
      // Out of hops, so this router is the destination
      route[PORT_PE] = 1'b1;
    end
  end

  // Upstream only sends while it holds a credit, so a full FIFO is never written
  a_no_overflow : assert property (
    @(posedge clk) disable iff (reset)
    in_valid |-> (count != credit_t'(BUFFER_DEPTH))
  ) else $error("input_port: flit written while the FIFO is full");

  // Grants only come back for a head flit that was offered
  a_no_underflow : assert property (
    @(posedge clk) disable iff (reset)
    pop |-> head_valid
  ) else $error("input_port: pop while the FIFO is empty");

endmodule

/* output_port.sv */
module output_port
  import flit_pkg::*;
  import router_cfg_pkg::*;
(
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   is_ring,
  input  port_mask_t             req_valid,
  input  flit_t [NUM_PORTS-1:0]  req_flits,
  input  logic                   credit_in,
  output port_mask_t             grant,
  output logic                   out_valid,
  output flit_t                  out_flit
);

  credit_t credits;
  port_e   last_port;
  port_e   sel_port;
  logic    send;
  logic    found;
  int      cand;
  flit_t   sel_flit;
  hop_t    sel_hops;
  flit_t   next_flit;

  // Round-robin search that starts just after the last winner.
  // No grant at all while the downstream buffer has no free slot
  always_comb begin
    grant    = '0;
    sel_port = last_port;
    found    = 1'b0;
    cand     = 0;
    if (credits != '0) begin
      for (int i = 1; i <= NUM_PORTS; i++) begin
        cand = (int'(last_port) + i) % NUM_PORTS;
        if (!found && req_valid[cand]) begin
          found       = 1'b1;
          grant[cand] = 1'b1;
          sel_port    = port_e'(cand);
        end
      end
    end
  end

  assign send = found;

  assign sel_flit = req_flits[sel_port];
  assign sel_hops = sel_flit[X_HOP_MSB:X_HOP_LSB];

  // Ring outputs consume one hop, the local port passes the flit unchanged
  always_comb begin
    next_flit = sel_flit;
    if (is_ring) begin
      next_flit[X_HOP_MSB:X_HOP_LSB] = sel_hops - hop_t'(1);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
      credits   <= credit_t'(BUFFER_DEPTH);
      // The cw input gets first pick after reset
      last_port <= PORT_PE;
    end else begin
      out_valid <= send;
      credits   <= credits + credit_t'(credit_in) - credit_t'(send);
      if (send) begin
        last_port <= sel_port;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (send) begin
      out_flit <= next_flit;
    end
  end

  // Downstream never returns more credits than it has slots
  a_credit_bound : assert property (
    @(posedge clk) disable iff (reset)
    credits <= credit_t'(BUFFER_DEPTH)
  ) else $error("output_port: credit counter above buffer depth");

  // A flit on the output must have been paid for with a credit
  a_send_with_credit : assert property (
    @(posedge clk) disable iff (reset)
    out_valid |-> ($past(credits) != '0)
  ) else $error("output_port: flit sent without a credit");

  a_grant_onehot : assert property (
    @(posedge clk) disable iff (reset)
    $onehot0(grant)
  ) else $error("output_port: more than one input granted");

endmodule

/* ring_router.sv */
module ring_router
  import flit_pkg::*;
  import router_cfg_pkg::*;
(
  input  logic  clk,
  input  logic  reset,

  input  logic  cw_in_valid,
  input  flit_t cw_in_flit,
  output logic  cw_credit_out,
  output logic  cw_out_valid,
  output flit_t cw_out_flit,
  input  logic  cw_credit_in,

  input  logic  ccw_in_valid,
  input  flit_t ccw_in_flit,
  output logic  ccw_credit_out,
  output logic  ccw_out_valid,
  output flit_t ccw_out_flit,
  input  logic  ccw_credit_in,

  input  logic  pe_in_valid,
  input  flit_t pe_in_flit,
  output logic  pe_credit_out,
  output logic  pe_out_valid,
  output flit_t pe_out_flit,
  input  logic  pe_credit_in
);

  port_mask_t                 in_valid;
  flit_t      [NUM_PORTS-1:0] in_flit;
  port_mask_t                 credit_out;
  port_mask_t                 credit_in;
  port_mask_t                 out_valid;
  flit_t      [NUM_PORTS-1:0] out_flit;
  port_mask_t                 head_valid;
  flit_t      [NUM_PORTS-1:0] head_flit;
  port_mask_t                 pop;
  // Indexed by input port
  port_mask_t [NUM_PORTS-1:0] route;
  // Indexed by output port, each bit names an input
  port_mask_t [NUM_PORTS-1:0] req_valid;
  port_mask_t [NUM_PORTS-1:0] grant;

  assign in_valid  = {pe_in_valid, ccw_in_valid, cw_in_valid};
  assign in_flit   = {pe_in_flit, ccw_in_flit, cw_in_flit};
  assign credit_in = {pe_credit_in, ccw_credit_in, cw_credit_in};

  assign cw_credit_out  = credit_out[PORT_CW];
  assign ccw_credit_out = credit_out[PORT_CCW];
  assign pe_credit_out  = credit_out[PORT_PE];
  assign cw_out_valid   = out_valid[PORT_CW];
  assign ccw_out_valid  = out_valid[PORT_CCW];
  assign pe_out_valid   = out_valid[PORT_PE];
  assign cw_out_flit    = out_flit[PORT_CW];
  assign ccw_out_flit   = out_flit[PORT_CCW];
  assign pe_out_flit    = out_flit[PORT_PE];

  for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
    input_port u_input (
      .clk        (clk),
      .reset      (reset),
      .in_valid   (in_valid[p]),
      .in_flit    (in_flit[p]),
      .is_pe_port (p == PORT_PE),
      .own_port   (port_e'(p)),
      .pop        (pop[p]),
      .credit_out (credit_out[p]),
      .head_valid (head_valid[p]),
      .head_flit  (head_flit[p]),
      .route      (route[p])
    );

    output_port u_output (
      .clk        (clk),
      .reset      (reset),
      .is_ring    (p != PORT_PE),
      .req_valid  (req_valid[p]),
      .req_flits  (head_flit),
      .credit_in  (credit_in[p]),
      .grant      (grant[p]),
      .out_valid  (out_valid[p]),
      .out_flit   (out_flit[p])
    );
  end

  // Requests are the transpose of the routes, and each input pops when any output takes it
  always_comb begin
    for (int o = 0; o < NUM_PORTS; o++) begin
      for (int i = 0; i < NUM_PORTS; i++) begin
        req_valid[o][i] = head_valid[i] & route[i][o];
      end
    end
    for (int i = 0; i < NUM_PORTS; i++) begin
      pop[i] = 1'b0;
      for (int o = 0; o < NUM_PORTS; o++) begin
        pop[i] = pop[i] | grant[o][i];
      end
    end
  end

endmodule

/* router_checker.sv */
module router_checker
  import flit_pkg::*;
  import router_cfg_pkg::*;
(
  input  logic                      clk,
  input  logic                      reset,
  input  port_mask_t                in_valid,
  input  port_mask_t                credit_out,
  input  port_mask_t                out_valid,
  input  flit_t [NUM_PORTS-1:0]     out_flit,
  input  port_mask_t                credit_in,
  input  port_mask_t                exp_valid,
  input  logic [NUM_PORTS-1:0][1:0] exp_dst,
  input  flit_t [NUM_PORTS-1:0]     exp_flit,
  input  logic                      check_counts,
  output int                        mismatches,
  output int                        other_errors,
  output int                        pending
);
  timeunit 1ns;
  timeprecision 1ps;

  // One queue per source and destination pair at index src * NUM_PORTS + dst
  flit_t q [NUM_PORTS*NUM_PORTS][$];
  int    accepted [NUM_PORTS];
  int    freed [NUM_PORTS];
  int    in_flight [NUM_PORTS];
  logic  reset_d = 1'b0;
  string names [NUM_PORTS] = '{"cw", "ccw", "pe"};

  initial begin
    mismatches = 0;
    other_errors = 0;
    pending = 0;
  end

  always @(posedge clk) begin
    int    src;
    logic  found;
    flit_t want;
    // Outputs were cleared at the previous edge if reset was high there
    if (reset_d && (out_valid !== '0 || credit_out !== '0)) begin
      other_errors++;
      $display("%0t: an output or credit pulse is active right after reset", $time);
    end
    reset_d = reset;
    for (int p = 0; p < NUM_PORTS; p++) begin
      if (exp_valid[p]) begin
        q[p*NUM_PORTS + int'(exp_dst[p])].push_back(exp_flit[p]);
        pending++;
      end
      accepted[p] += int'(in_valid[p]);
      freed[p] += int'(credit_out[p]);
      in_flight[p] += int'(out_valid[p]) - int'(credit_in[p]);
      if (in_flight[p] > BUFFER_DEPTH) begin
        other_errors++;
        $display("%0t: %s output sent more flits than it had credits", $time, names[p]);
      end
      if (out_valid[p]) begin
        src = int'(out_flit[p][33:32]);
        found = (src < NUM_PORTS);
        if (found) found = (q[src*NUM_PORTS + p].size() != 0);
        if (!found) begin
          other_errors++;
          $display("%0t: unexpected flit %h on %s output", $time, out_flit[p], names[p]);
        end else begin
          want = q[src*NUM_PORTS + p].pop_front();
          pending--;
          if (out_flit[p] !== want) begin
            mismatches++;
            $display("Mismatch at %0t: %s_out_flit expected %h, got %h",
                     $time, names[p], want, out_flit[p]);
          end
        end
      end
      if (check_counts && accepted[p] != freed[p]) begin
        other_errors++;
        $display("%s input returned %0d credits for %0d accepted flits",
                 names[p], freed[p], accepted[p]);
      end
    end
  end

endmodule

/* tb_ring_router.sv */
module tb_ring_router
  import flit_pkg::*;
  import router_cfg_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int TIMEOUT = 400;

  // One row of the stimulus table with the output port and hop count it should reach
  typedef struct {
    port_e src;
    logic  ew;
    hop_t  hops;
    port_e dst;
    hop_t  exp_hops;
    logic  with_next;
  } stim_t;

  logic                               clk = 1'b0;
  logic                               reset = 1'b1;
  port_mask_t                         in_valid = '0;
  flit_t      [NUM_PORTS-1:0]         in_flit = '0;
  port_mask_t                         credit_in = '0;
  wire        [NUM_PORTS-1:0]         credit_out;
  wire        [NUM_PORTS-1:0]         out_valid;
  wire        [NUM_PORTS-1:0][FLIT_WIDTH-1:0] out_flit;
  port_mask_t                         exp_valid = '0;
  logic       [NUM_PORTS-1:0][1:0]    exp_dst = '0;
  flit_t      [NUM_PORTS-1:0]         exp_flit = '0;
  logic                               check_counts = 1'b0;
  logic                               return_en = 1'b1;
  logic       [31:0]                  lfsr = 32'hc273_5b13;
  int                                 up_credits [NUM_PORTS];
  int                                 held [NUM_PORTS];
  int                                 mismatches;
  int                                 other_errors;
  int                                 pending;
  int                                 tb_errors = 0;
  int                                 stall_start;
  stim_t                              stim [$];

  always #20 clk = ~clk;

  ring_router DUT (
    .clk            (clk),
    .reset          (reset),
    .cw_in_valid    (in_valid[PORT_CW]),
    .cw_in_flit     (in_flit[PORT_CW]),
    .cw_credit_out  (credit_out[PORT_CW]),
    .cw_out_valid   (out_valid[PORT_CW]),
    .cw_out_flit    (out_flit[PORT_CW]),
    .cw_credit_in   (credit_in[PORT_CW]),
    .ccw_in_valid   (in_valid[PORT_CCW]),
    .ccw_in_flit    (in_flit[PORT_CCW]),
    .ccw_credit_out (credit_out[PORT_CCW]),
    .ccw_out_valid  (out_valid[PORT_CCW]),
    .ccw_out_flit   (out_flit[PORT_CCW]),
    .ccw_credit_in  (credit_in[PORT_CCW]),
    .pe_in_valid    (in_valid[PORT_PE]),
    .pe_in_flit     (in_flit[PORT_PE]),
    .pe_credit_out  (credit_out[PORT_PE]),
    .pe_out_valid   (out_valid[PORT_PE]),
    .pe_out_flit    (out_flit[PORT_PE]),
    .pe_credit_in   (credit_in[PORT_PE])
  );

  router_checker u_checker (
    .clk          (clk),
    .reset        (reset),
    .in_valid     (in_valid),
    .credit_out   (credit_out),
    .out_valid    (out_valid),
    .out_flit     (out_flit),
    .credit_in    (credit_in),
    .exp_valid    (exp_valid),
    .exp_dst      (exp_dst),
    .exp_flit     (exp_flit),
    .check_counts (check_counts),
    .mismatches   (mismatches),
    .other_errors (other_errors),
    .pending      (pending)
  );

  // Fibonacci LFSR with taps 32, 22, 2 and 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic flit_t make_flit(input int k, input hop_t hops);
    flit_t f;
    f = '0;
    f[63:62] = 2'(k);
    f[EAST_WEST_BIT] = stim[k].ew;
    f[55:52] = 4'(k + 3);
    f[X_HOP_MSB:X_HOP_LSB] = hops;
    // The low source bits tag the input port so the checker can pick a queue
    f[47:32] = 16'(stim[k].src);
    f[31:0] = payload_t'(32'h5a00_0000 + 32'(k));
    return f;
  endfunction

  task automatic add_entry(input port_e src, input logic ew, input hop_t hops,
                           input port_e dst, input hop_t exp_hops, input logic with_next);
    stim_t e;
    e.src = src;
    e.ew = ew;
    e.hops = hops;
    e.dst = dst;
    e.exp_hops = exp_hops;
    e.with_next = with_next;
    stim.push_back(e);
  endtask

  task automatic send_entry(input int k);
    port_e s;
    s = stim[k].src;
    in_valid[s] = 1'b1;
    in_flit[s] = make_flit(k, stim[k].hops);
    exp_valid[s] = 1'b1;
    exp_dst[s] = stim[k].dst;
    exp_flit[s] = make_flit(k, stim[k].exp_hops);
  endtask

  // Every input used by the batch must hold an upstream credit
  task automatic wait_credits(input int first, input int last, output logic ok);
    int t;
    ok = 1'b0;
    for (t = 0; t < TIMEOUT && !ok; t++) begin
      ok = 1'b1;
      for (int k = first; k <= last; k++) begin
        if (up_credits[stim[k].src] == 0) ok = 1'b0;
      end
      if (!ok) begin
        @(posedge clk);
        #2;
      end
    end
  endtask

  task automatic wait_idle(input string phase);
    int t;
    for (t = 0; t < TIMEOUT; t++) begin
      if (pending == 0 && held[0] == 0 && held[1] == 0 && held[2] == 0) break;
      @(posedge clk);
      #2;
    end
    if (t == TIMEOUT) begin
      tb_errors++;
      $display("Timeout %s: %0d expected flits never arrived", phase, pending);
    end
  endtask

  task automatic wait_cw_full();
    int t;
    for (t = 0; t < TIMEOUT; t++) begin
      if (held[PORT_CW] == BUFFER_DEPTH) break;
      @(posedge clk);
      #2;
    end
    if (t == TIMEOUT) begin
      tb_errors++;
      $display("Timeout: cw output never filled its downstream buffer");
    end
  endtask

  // Upstream keeps one credit per free slot in each input FIFO
  always @(posedge clk) begin
    for (int p = 0; p < NUM_PORTS; p++) begin
      if (reset) begin
        up_credits[p] <= BUFFER_DEPTH;
      end else begin
        up_credits[p] <= up_credits[p] + int'(credit_out[p]) - int'(in_valid[p]);
      end
    end
  end

  // Downstream holds each delivered flit and frees its slot at random
  always @(posedge clk) begin
    for (int p = 0; p < NUM_PORTS; p++) begin
      held[p] = reset ? 0 : held[p] + int'(out_valid[p]) - int'(credit_in[p]);
    end
    #2;
    for (int p = 0; p < NUM_PORTS; p++) begin
      lfsr = lfsr_next(lfsr);
      credit_in[p] = !reset && return_en && (held[p] > 0) && lfsr[0];
    end
  end

  initial begin
    int   first;
    int   last;
    logic ok;
    add_entry(PORT_PE, 1'b1, 4'd3, PORT_CW, 4'd2, 1'b0);
    add_entry(PORT_PE, 1'b0, 4'd1, PORT_CCW, 4'd0, 1'b0);
    add_entry(PORT_PE, 1'b1, 4'd15, PORT_CW, 4'd14, 1'b0);
    add_entry(PORT_CW, 1'b0, 4'd5, PORT_CW, 4'd4, 1'b0);
    add_entry(PORT_CCW, 1'b1, 4'd2, PORT_CCW, 4'd1, 1'b0);
    add_entry(PORT_CW, 1'b1, 4'd0, PORT_PE, 4'd0, 1'b0);
    add_entry(PORT_CCW, 1'b0, 4'd0, PORT_PE, 4'd0, 1'b0);
    // Three inputs meet at pe, then two inputs meet at each ring
    for (int r = 0; r < 3; r++) begin
      add_entry(PORT_CW, 1'b0, 4'd0, PORT_PE, 4'd0, 1'b1);
      add_entry(PORT_CCW, 1'b1, 4'd0, PORT_PE, 4'd0, 1'b1);
      add_entry(PORT_PE, 1'b0, 4'd0, PORT_PE, 4'd0, 1'b0);
      add_entry(PORT_CW, 1'b0, 4'd4, PORT_CW, 4'd3, 1'b1);
      add_entry(PORT_PE, 1'b1, 4'd1, PORT_CW, 4'd0, 1'b0);
      add_entry(PORT_CCW, 1'b0, 4'd7, PORT_CCW, 4'd6, 1'b1);
      add_entry(PORT_PE, 1'b0, 4'd2, PORT_CCW, 4'd1, 1'b0);
    end
    // Sent while downstream returns no credits
    stall_start = stim.size();
    for (int r = 0; r < 4; r++) begin
      add_entry(PORT_PE, 1'b1, 4'd2, PORT_CW, 4'd1, 1'b1);
      add_entry(PORT_CW, 1'b0, 4'd3, PORT_CW, 4'd2, 1'b0);
    end

    repeat (10) @(posedge clk);
    #2;
    reset = 1'b0;
    first = 0;
    while (first < stim.size()) begin
      if (first == stall_start) begin
        wait_idle("before back-pressure");
        return_en = 1'b0;
      end
      last = first;
      while (stim[last].with_next) last++;
      wait_credits(first, last, ok);
      if (!ok) begin
        tb_errors++;
        $display("Timeout: no upstream credit for table entry %0d", first);
        break;
      end
      for (int k = first; k <= last; k++) send_entry(k);
      @(posedge clk);
      #2;
      in_valid = '0;
      exp_valid = '0;
      first = last + 1;
    end
    wait_cw_full();
    repeat (20) @(posedge clk);
    // Credits resume with the next return decision
    return_en = 1'b1;
    #2;
    wait_idle("after back-pressure");
    check_counts = 1'b1;
    @(posedge clk);
    #2;
    check_counts = 1'b0;
    $display("Errors: %0d mismatches, %0d checker errors, %0d testbench errors",
             mismatches, other_errors, tb_errors);
    if (mismatches + other_errors + tb_errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

/* ring_router.f */
flit_pkg.sv
router_cfg_pkg.sv
input_port.sv
output_port.sv
ring_router.sv
router_checker.sv
tb_ring_router.sv

/* run_sim.sh */
#!/bin/sh
# Builds the ring router testbench with Verilator and runs it.
# Exits with 0 only when the simulation reports a pass.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_ring_router -f ring_router.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/Vtb_ring_router)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "Testbench passed"; then
  exit 0
fi
exit 1
